// File: run.sh
#!/bin/sh
# build and run the UART echo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module uart_echo_tb \
	-f tb.f \
	-o uart_echo_sim

./obj_dir/uart_echo_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
	exit 0
else
	exit 1
fi

// File: source/byte_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module byte_fifo import uart_pkg::*, cmd_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input serial_byte_t push,
	input logic pop,
	output logic [7:0] pop_data,
	output logic empty,
	output logic full
);

	logic [7:0] mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push.valid && !full; // byte lost when full
	assign do_pop = pop && !empty;
	assign empty = (count == '0);
	assign full = count[$clog2(FIFO_DEPTH)]; // msb set only at FIFO_DEPTH
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= push.data;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (!rst_n) !(push.valid && full))
		else $error("rx byte dropped, fifo full");

	assert property (@(posedge CLK) disable iff (!rst_n) !(pop && empty))
		else $error("pop from empty fifo");

endmodule

`default_nettype wire

// File: source/cmd_decode.sv
`default_nettype none
`timescale 1ns/1ns

module cmd_decode import cmd_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input logic [7:0] pop_data,
	input logic empty,
	output logic pop,
	output decoded_cmd_t dec_cmd,
	output logic dec_valid,
	input logic dec_ready
);

	opcode_t op_next;
	logic is_upper;
	logic is_lower;

	assign is_upper = (pop_data >= CHAR_UPPER_A) && (pop_data <= CHAR_UPPER_Z);
	assign is_lower = (pop_data >= CHAR_LOWER_A) && (pop_data <= CHAR_LOWER_Z);

	always_comb begin
		if (pop_data == QUERY_BYTE)
			op_next = OP_QUERY;
		else if (is_upper || is_lower)
			op_next = OP_SWAP_CASE;
		else
			op_next = OP_ECHO;
	end

	// take a new byte when the register is free or leaving
	assign pop = !empty && (!dec_valid || dec_ready);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			dec_cmd <= '{op: OP_ECHO, data: 8'h00};
			dec_valid <= 1'b0;
		end else if (pop) begin
			dec_cmd <= '{op: op_next, data: pop_data};
			dec_valid <= 1'b1;
		end else if (dec_ready)
			dec_valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: source/cmd_execute.sv
`default_nettype none
`timescale 1ns/1ns

module cmd_execute import cmd_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input decoded_cmd_t dec_cmd,
	input logic dec_valid,
	output logic dec_ready,
	output reply_t exe_reply,
	output logic exe_valid,
	input logic exe_ready
);

	logic [7:0] byte_cnt; // non-query commands, wraps at 256
	logic accept;
	reply_t reply_next;

	assign dec_ready = !exe_valid || exe_ready;
	assign accept = dec_valid && dec_ready;

	always_comb begin
		reply_next.data = dec_cmd.data;
		unique case (dec_cmd.op)
			OP_SWAP_CASE: reply_next.data[CASE_BIT] = ~dec_cmd.data[CASE_BIT];
			OP_QUERY: reply_next.data = byte_cnt;
			default: reply_next.data = dec_cmd.data; // echo
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
			byte_cnt <= '0;
		end else begin
			if (accept) begin
				exe_valid <= 1'b1;
				if (dec_cmd.op != OP_QUERY)
					byte_cnt <= byte_cnt + 1'b1;
			end else if (exe_ready)
				exe_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			exe_reply <= reply_next;
	end

endmodule

`default_nettype wire

// File: source/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	localparam int FIFO_DEPTH = 256; // power of two

	localparam logic [7:0] QUERY_BYTE = 8'h3F; // '?'

	// letter ranges, ASCII
	localparam logic [7:0] CHAR_UPPER_A = 8'h41;
	localparam logic [7:0] CHAR_UPPER_Z = 8'h5A;
	localparam logic [7:0] CHAR_LOWER_A = 8'h61;
	localparam logic [7:0] CHAR_LOWER_Z = 8'h7A;

	localparam int CASE_BIT = 5; // upper and lower differ only here

	typedef enum logic [1:0] {
		OP_ECHO,
		OP_SWAP_CASE,
		OP_QUERY
	} opcode_t;

	typedef struct packed {
		opcode_t op;
		logic [7:0] data; // byte as received
	} decoded_cmd_t;

	typedef struct packed {
		logic [7:0] data;
	} reply_t;

endpackage

`default_nettype wire

// File: source/reply_stage.sv
`default_nettype none
`timescale 1ns/1ns

module reply_stage import uart_pkg::*, cmd_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input reply_t exe_reply,
	input logic exe_valid,
	output logic exe_ready,
	output serial_byte_t tx_byte,
	input logic tx_ready,
	output logic [7:0] led
);

	logic tx_take;

	assign tx_take = tx_byte.valid && tx_ready;
	assign exe_ready = !tx_byte.valid || tx_ready;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			tx_byte <= '0;
			led <= 8'hFF; // leds are active low
		end else begin
			if (tx_take)
				led <= ~tx_byte.data;
			if (exe_valid && exe_ready)
				tx_byte <= '{data: exe_reply.data, valid: 1'b1};
			else if (tx_take)
				tx_byte.valid <= 1'b0;
		end
	end

	// upstream reply must hold while stalled
	assert property (@(posedge CLK) disable iff (!rst_n)
		(exe_valid && !exe_ready) |=> (exe_valid && $stable(exe_reply)))
		else $error("exe_reply changed while waiting for reply register");

endmodule

`default_nettype wire

// File: source/uart_echo_top.sv
`default_nettype none
`timescale 1ns/1ns

module uart_echo_top import uart_pkg::*, cmd_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input logic rx,
	output logic tx,
	output logic [7:0] led
);

	serial_byte_t rx_byte;
	serial_byte_t tx_byte;
	logic [7:0] pop_data;
	logic empty;
	logic pop;
	decoded_cmd_t dec_cmd;
	logic dec_valid;
	logic dec_ready;
	reply_t exe_reply;
	logic exe_valid;
	logic exe_ready;
	logic tx_ready;

	uart_rx uart_rx_i (
		.CLK(CLK), .rst_n(rst_n), .rx(rx), .rx_byte(rx_byte)
	);

	// full is only needed inside the FIFO
	byte_fifo byte_fifo_i (
		.CLK(CLK), .rst_n(rst_n), .push(rx_byte), .pop(pop),
		.pop_data(pop_data), .empty(empty), .full()
	);

	cmd_decode cmd_decode_i (
		.CLK(CLK), .rst_n(rst_n), .pop_data(pop_data), .empty(empty), .pop(pop),
		.dec_cmd(dec_cmd), .dec_valid(dec_valid), .dec_ready(dec_ready)
	);

	cmd_execute cmd_execute_i (
		.CLK(CLK), .rst_n(rst_n), .dec_cmd(dec_cmd), .dec_valid(dec_valid),
		.dec_ready(dec_ready), .exe_reply(exe_reply), .exe_valid(exe_valid),
		.exe_ready(exe_ready)
	);

	reply_stage reply_stage_i (
		.CLK(CLK), .rst_n(rst_n), .exe_reply(exe_reply), .exe_valid(exe_valid),
		.exe_ready(exe_ready), .tx_byte(tx_byte), .tx_ready(tx_ready), .led(led)
	);

	uart_tx uart_tx_i (
		.CLK(CLK), .rst_n(rst_n), .tx_byte(tx_byte), .tx_ready(tx_ready), .tx(tx)
	);

endmodule

`default_nettype wire

// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

	localparam int CLK_FRE_MHZ = 50; // board clock in MHz
	localparam int BAUD_RATE = 115200;

	// integer division rounds down, 434 at 50 MHz
	localparam int CYCLES_PER_BIT = CLK_FRE_MHZ * 1_000_000 / BAUD_RATE;

	// one byte on its way into or out of a serial port
	typedef struct packed {
		logic [7:0] data;
		logic valid; // request, or one-cycle pulse from rx
	} serial_byte_t;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`default_nettype none
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input logic rx,
	output serial_byte_t rx_byte
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [15:0] cyc_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;

	// line idles high
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			cyc_cnt <= '0;
			bit_idx <= '0;
			shift_reg <= '0;
			rx_byte <= '0;
		end else begin
			rx_byte.valid <= 1'b0; // pulse only
			case (state)
				RX_IDLE: begin
					cyc_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (cyc_cnt == 16'(CYCLES_PER_BIT / 2 - 1)) begin
						cyc_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA; // glitch, not a start bit
					end else
						cyc_cnt <= cyc_cnt + 1'b1;
				end
				RX_DATA: begin
					if (cyc_cnt == 16'(CYCLES_PER_BIT - 1)) begin
						cyc_cnt <= '0;
						shift_reg <= {rx_sync, shift_reg[7:1]}; // lsb first
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else
						cyc_cnt <= cyc_cnt + 1'b1;
				end
				RX_STOP: begin
					if (cyc_cnt == 16'(CYCLES_PER_BIT - 1)) begin
						cyc_cnt <= '0;
						state <= RX_IDLE;
						if (rx_sync) begin
							rx_byte.data <= shift_reg;
							rx_byte.valid <= 1'b1;
						end
					end else
						cyc_cnt <= cyc_cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input serial_byte_t tx_byte,
	output logic tx_ready,
	output logic tx
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t state;
	logic [15:0] cyc_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;
	logic bit_end;

	assign tx_ready = (state == TX_IDLE);
	assign bit_end = (cyc_cnt == 16'(CYCLES_PER_BIT - 1));

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			cyc_cnt <= '0;
			bit_idx <= '0;
			shift_reg <= '0;
			tx <= 1'b1;
		end else begin
			cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					cyc_cnt <= '0;
					if (tx_byte.valid) begin
						shift_reg <= tx_byte.data;
						tx <= 1'b0; // start bit from next cycle
						state <= TX_START;
					end
				end
				TX_START: if (bit_end) begin
					tx <= shift_reg[0];
					bit_idx <= '0;
					state <= TX_DATA;
				end
				TX_DATA: if (bit_end) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						tx <= 1'b1;
						state <= TX_STOP;
					end else begin
						tx <= shift_reg[1];
						shift_reg <= shift_reg >> 1;
					end
				end
				TX_STOP: if (bit_end)
					state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// line must rest at mark level between frames
	assert property (@(posedge CLK) disable iff (!rst_n) (state == TX_IDLE) |-> tx)
		else $error("tx low while transmitter idle");

endmodule

`default_nettype wire

// File: tb.f
source/uart_pkg.sv
source/cmd_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/byte_fifo.sv
source/cmd_decode.sv
source/cmd_execute.sv
source/reply_stage.sv
source/uart_echo_top.sv
verification/uart_echo_tb.sv

// File: verification/uart_echo_tb.sv
`default_nettype none
`timescale 1ns/1ns

module uart_echo_tb import uart_pkg::*, cmd_pkg::*;;

	localparam int N_FIXED = 18;
	localparam int N_BURST = 40;
	localparam int N_BYTES = N_FIXED + N_BURST;
	localparam int CYCLE_LIMIT = N_BYTES * 12 * CYCLES_PER_BIT + 40 * CYCLES_PER_BIT;
	localparam int DRAIN_LIMIT = 30 * CYCLES_PER_BIT; // a few frames after the last byte

	// query first, digits, punctuation, both cases, two queries in a row, range edges
	localparam logic [7:0] FIXED_BYTES [N_FIXED] = '{
		8'h3F, 8'h30, 8'h39, 8'h21, 8'h20, 8'h61, 8'h7A, 8'h41, 8'h5A,
		8'h6D, 8'h3F, 8'h3F, 8'h40, 8'h5B, 8'h60, 8'h7B, 8'hFF, 8'h00
	};

	logic CLK;
	logic rst_n;
	logic rx;
	logic tx;
	logic [7:0] led;

	logic [7:0] exp_q [$]; // replies not yet seen on tx
	logic [7:0] nonquery_cnt;
	logic [31:0] lfsr_state;
	int cycle_cnt;
	int mismatch_cnt;
	int other_err_cnt;
	int reply_cnt;

	uart_echo_top uart_echo_top_i (
		.CLK(CLK), .rst_n(rst_n), .rx(rx), .tx(tx), .led(led)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic next_random_byte(output logic [7:0] b);
		int i;
		for (i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0]; // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// reply rule applied in send order
	task automatic queue_expected(input logic [7:0] b);
		logic is_letter;
		is_letter = (b >= 8'h41 && b <= 8'h5A) || (b >= 8'h61 && b <= 8'h7A);
		if (b == QUERY_BYTE)
			exp_q.push_back(nonquery_cnt);
		else begin
			exp_q.push_back(is_letter ? (b ^ 8'h20) : b);
			nonquery_cnt = nonquery_cnt + 8'd1;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK);
		#2;
	endtask

	task automatic send_byte(input logic [7:0] b);
		int i;
		queue_expected(b);
		rx = 1'b0; // start
		wait_cycles(CYCLES_PER_BIT);
		for (i = 0; i < 8; i++) begin
			rx = b[i];
			wait_cycles(CYCLES_PER_BIT);
		end
		rx = 1'b1; // stop
		wait_cycles(CYCLES_PER_BIT);
	endtask

	// rebuilds each tx frame from mid-bit samples
	initial begin : tx_monitor
		logic [7:0] got;
		logic [7:0] exp;
		int i;
		@(posedge rst_n);
		forever begin
			@(negedge tx);
			repeat (CYCLES_PER_BIT / 2) @(negedge CLK);
			assert (tx == 1'b0) else begin
				other_err_cnt++;
				$display("start bit on tx did not stay low at %0t", $time);
			end
			for (i = 0; i < 8; i++) begin
				repeat (CYCLES_PER_BIT) @(negedge CLK);
				got[i] = tx;
			end
			repeat (CYCLES_PER_BIT) @(negedge CLK);
			assert (tx == 1'b1) else begin
				other_err_cnt++;
				$display("stop bit on tx was low at %0t", $time);
			end
			if (exp_q.size() == 0) begin
				other_err_cnt++;
				$display("reply 0x%02h arrived with no byte outstanding at %0t", got, $time);
			end else begin
				exp = exp_q.pop_front();
				reply_cnt++;
				assert (got == exp) else begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: reply 0x%02h, expected 0x%02h", $time, got, exp);
				end
				assert (led == ~exp) else begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: led 0x%02h, expected 0x%02h", $time, led, ~exp);
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles with %0d replies missing",
				cycle_cnt, exp_q.size());
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin : stimulus
		logic [7:0] b;
		int i;
		rx = 1'b1;
		rst_n = 1'b0;
		nonquery_cnt = 8'd0;
		lfsr_state = 32'h2c58_c864;
		cycle_cnt = 0;
		mismatch_cnt = 0;
		other_err_cnt = 0;
		reply_cnt = 0;
		wait_cycles(16);
		rst_n = 1'b1;

		// idle line and dark leds before any byte
		for (i = 0; i < 3 * CYCLES_PER_BIT; i++) begin
			@(negedge CLK);
			assert (tx == 1'b1 && led == 8'hFF) else begin
				mismatch_cnt++;
				$display("MISMATCH at %0t: idle tx %b led 0x%02h", $time, tx, led);
			end
		end
		wait_cycles(1);

		for (i = 0; i < N_FIXED; i++) begin
			send_byte(FIXED_BYTES[i]);
			wait_cycles(2 * CYCLES_PER_BIT);
		end
		for (i = 0; i < N_BURST; i++) begin
			next_random_byte(b);
			send_byte(b); // back to back
		end

		i = 0;
		while (exp_q.size() != 0 && i < DRAIN_LIMIT) begin
			@(posedge CLK);
			i++;
		end
		wait_cycles(20 * CYCLES_PER_BIT); // room for a duplicate to show up

		assert (exp_q.size() == 0 && reply_cnt == N_BYTES) else begin
			other_err_cnt++;
			$display("%0d of %0d replies received", reply_cnt, N_BYTES);
		end
		$display("errors: %0d mismatches, %0d other, %0d replies checked",
			mismatch_cnt, other_err_cnt, reply_cnt);
		if (mismatch_cnt == 0 && other_err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
